// File: verilog.f
+incdir+hw
hw/pinwkup_pkg.sv
hw/pinwkup_filter.sv
hw/pinwkup_detector.sv
hw/pinwkup_top.sv
test/tb_pinwkup.sv

// File: Makefile
# Verilator flow for the pin wakeup detector bank

TOP = tb_pinwkup

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f verilog.f --top-module $(TOP) -o V$(TOP)

# Pass or fail is decided from the log
run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Verification failed" sim.log; then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "Verification passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module pinwkup_top

clean:
	rm -rf obj_dir sim.log

// File: test/tb_pinwkup.sv
// Testbench for the pin wakeup detector bank
// Reference model, compare task, watchdog, directed and random cases

`timescale 1ns/1ps
`default_nettype none

`include "pinwkup_config.svh"

module tb_pinwkup import pinwkup_pkg::*; ();

  localparam int NDET = `PINWKUP_NUM_DET;
  localparam int FILT = `PINWKUP_FILTER_CYCLES;
  // Allowed delay after the stimulus, raw and debounced
  localparam int LAT_RAW  = 4;
  localparam int LAT_FILT = FILT + 6;

  logic                 clk_aon;
  logic                 rst_aon_n;
  logic      [NDET-1:0] pad;
  wkup_cfg_t [NDET-1:0] cfg;
  logic      [NDET-1:0] cause_clr;
  logic      [NDET-1:0] cause;
  logic                 wkup_req;

  int seed          = 14125;
  int num_tests     = 0;
  int num_bad_tests = 0;
  int num_errors    = 0;

  wkup_mode_e edge_modes [3] = '{WKUP_POSEDGE, WKUP_NEGEDGE, WKUP_EDGE};

  pinwkup_top i_dut (
    .clk_aon_i   (clk_aon),
    .rst_aon_ni  (rst_aon_n),
    .pad_i       (pad),
    .wkup_cfg_i  (cfg),
    .cause_clr_i (cause_clr),
    .cause_o     (cause),
    .wkup_req_o  (wkup_req)
  );

  // 8 ns clock
  initial begin : p_clk
    clk_aon = 1'b0;
    forever #4 clk_aon = ~clk_aon;
  end

  // About 2000 cycles of tests, so 50 us leaves ample margin
  initial begin : p_watchdog
    #50000;
    $display("Simulation timed out after 50 us, tests did not finish");
    $display("Verification failed");
    $finish;
  end

  ////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////

  // Pad leaves ~level, holds level for len cycles, returns only if ret
  function automatic logic predict_wake(input wkup_mode_e mode, input logic filt_en,
                                        input int th, input logic level, input int len,
                                        input logic ret);
    logic rise;
    logic fall;
    // Debounce swallows short glitches
    if (filt_en && len < FILT) return 1'b0;
    rise = level | (ret & ~level);
    fall = ~level | (ret & level);
    case (mode)
      WKUP_NEGEDGE:    return fall;
      WKUP_EDGE:       return rise | fall;
      WKUP_HIGH_TIMED: return level && (len >= th + 1);
      WKUP_LOW_TIMED:  return !level && (len >= th + 1);
      default:         return rise;
    endcase
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [NDET-1:0] cause_vec(input int det, input logic wake);
    logic [NDET-1:0] v;
    v      = '0;
    v[det] = wake;
    return v;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
      num_errors++;
    end
  endtask

  // Compare causes and request, then report the test
  task automatic finish_test(input string name, input logic [NDET-1:0] exp_cause);
    int errors_before;
    errors_before = num_errors;
    check_val({name, " cause"}, exp_cause, cause);
    check_val({name, " req"}, |exp_cause, wkup_req);
    num_tests++;
    if (num_errors != errors_before) begin
      num_bad_tests++;
      $display("test %0d %s: mismatch", num_tests, name);
    end else begin
      $display("test %0d %s: ok", num_tests, name);
    end
  endtask

  // Poll the cause bit, giving up after limit cycles
  task automatic wait_cause(input int det, input int limit);
    int n;
    n = 0;
    while (!cause[det] && n < limit) begin
      @(negedge clk_aon);
      n++;
    end
  endtask

  // Disable all, park the pads, clear causes, then enable one detector
  task automatic setup_det(input int det, input wkup_mode_e mode, input logic filt_en,
                           input int th, input logic idle);
    @(negedge clk_aon);
    for (int i = 0; i < NDET; i++) cfg[i] = '0;
    @(negedge clk_aon);
    pad      = '0;
    pad[det] = idle;
    repeat (12) @(negedge clk_aon);
    cause_clr = '1;
    @(negedge clk_aon);
    cause_clr = '0;
    cfg[det].mode      = mode;
    cfg[det].filter_en = filt_en;
    cfg[det].cnt_th    = wkup_cnt_t'(th);
    cfg[det].en        = 1'b1;
    repeat (4) @(negedge clk_aon);
  endtask

  task automatic run_case(input string name, input int det, input wkup_mode_e mode,
                          input logic filt_en, input int th, input logic level,
                          input int len, input logic ret);
    logic exp;
    exp = predict_wake(mode, filt_en, th, level, len, ret);
    setup_det(det, mode, filt_en, th, ~level);
    pad[det] = level;
    repeat (len) @(negedge clk_aon);
    if (ret) pad[det] = ~level;
    wait_cause(det, filt_en ? LAT_FILT : LAT_RAW);
    finish_test(name, cause_vec(det, exp));
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : p_main
    wkup_mode_e mode;
    logic       lvl;
    int         th;
    int         len;
    int         last;

    last      = NDET - 1;
    rst_aon_n = 1'b0;
    pad       = '0;
    cfg       = '0;
    cause_clr = '0;
    repeat (16) @(negedge clk_aon);
    rst_aon_n = 1'b1;

    // Reset state, and edges before any enable
    @(negedge clk_aon);
    finish_test("reset state", '0);
    pad = '1;
    repeat (6) @(negedge clk_aon);
    finish_test("edge before enable", '0);

    // Edge modes, wrong direction first
    for (int d = 0; d < NDET; d++) begin
      foreach (edge_modes[m]) begin
        lvl = (edge_modes[m] == WKUP_NEGEDGE);
        run_case($sformatf("edge d%0d %s wrong", d, edge_modes[m].name()), d,
                 edge_modes[m], 1'b0, 0, lvl, 6, 1'b0);
        run_case($sformatf("edge d%0d %s right", d, edge_modes[m].name()), d,
                 edge_modes[m], 1'b0, 0, ~lvl, 6, 1'b0);
      end
    end

    // Timed modes, lengths below and above threshold + 1
    for (int i = 0; i < 3; i++) begin
      for (int m = 0; m < 2; m++) begin
        mode = (m == 0) ? WKUP_HIGH_TIMED : WKUP_LOW_TIMED;
        lvl  = (m == 0);
        th   = 2 + rand_below(31);
        len  = 1 + rand_below(th);
        run_case($sformatf("timed d%0d %s th=%0d len=%0d", i, mode.name(), th, len),
                 i, mode, 1'b0, th, lvl, len, 1'b1);
        len  = th + 1 + rand_below(16);
        run_case($sformatf("timed d%0d %s th=%0d len=%0d", i, mode.name(), th, len),
                 i, mode, 1'b0, th, lvl, len, 1'b1);
      end
    end

    // Debounce against glitches
    len = 1 + rand_below(FILT - 1);
    run_case($sformatf("filter short len=%0d", len), 1, WKUP_POSEDGE, 1'b1, 0, 1'b1, len, 1'b1);
    run_case("filter long", 1, WKUP_POSEDGE, 1'b1, 0, 1'b1, FILT + 4, 1'b1);
    run_case($sformatf("no filter short len=%0d", len), 1, WKUP_POSEDGE, 1'b0, 0, 1'b1, len,
             1'b1);

    // Mode change while enabled is ignored
    setup_det(2, WKUP_POSEDGE, 1'b0, 0, 1'b1);
    cfg[2].mode = WKUP_NEGEDGE;
    pad[2]      = 1'b0;
    repeat (6) @(negedge clk_aon);
    wait_cause(2, LAT_RAW);
    finish_test("latch fall", cause_vec(2, predict_wake(WKUP_POSEDGE, 1'b0, 0, 1'b0, 6, 1'b0)));
    pad[2] = 1'b1;
    repeat (6) @(negedge clk_aon);
    wait_cause(2, LAT_RAW);
    finish_test("latch rise", cause_vec(2, predict_wake(WKUP_POSEDGE, 1'b0, 0, 1'b1, 6, 1'b0)));

    // Stickiness and clearing
    run_case("sticky set", last, WKUP_POSEDGE, 1'b0, 0, 1'b1, 3, 1'b1);
    repeat (8) @(negedge clk_aon);
    finish_test("sticky after pad returns", cause_vec(last, 1'b1));
    cfg[last].en = 1'b0;
    repeat (4) @(negedge clk_aon);
    finish_test("sticky after disable", cause_vec(last, 1'b1));
    // Second cause keeps the request up
    cfg[0].mode = WKUP_POSEDGE;
    cfg[0].en   = 1'b1;
    repeat (4) @(negedge clk_aon);
    pad[0] = 1'b1;
    wait_cause(0, LAT_RAW);
    finish_test("two causes", cause_vec(last, 1'b1) | cause_vec(0, 1'b1));
    cause_clr[last] = 1'b1;
    @(negedge clk_aon);
    cause_clr = '0;
    finish_test("clear one", cause_vec(0, 1'b1));
    cause_clr[0] = 1'b1;
    @(negedge clk_aon);
    cause_clr = '0;
    finish_test("clear all", '0);
    // Disabled detector ignores edges
    pad[last] = 1'b0;
    repeat (3) @(negedge clk_aon);
    pad[last] = 1'b1;
    repeat (3) @(negedge clk_aon);
    pad[last] = 1'b0;
    repeat (LAT_RAW + 2) @(negedge clk_aon);
    finish_test("disabled edges", '0);

    $display("Tests run %0d, failing tests %0d, mismatches %0d",
             num_tests, num_bad_tests, num_errors);
    if (num_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : tb_pinwkup

`default_nettype wire

// File: hw/pinwkup_top.sv
// Top level of the pin wakeup detector bank
// One detector per pad, causes ORed into a single wakeup request

`timescale 1ns/1ps
`default_nettype none

`include "pinwkup_config.svh"

module pinwkup_top import pinwkup_pkg::*; (
  input  logic                                 clk_aon_i,
  input  logic                                 rst_aon_ni,
  // Raw pads, asynchronous to the clock
  input  logic      [`PINWKUP_NUM_DET-1:0]     pad_i,
  // One config word per detector
  input  wkup_cfg_t [`PINWKUP_NUM_DET-1:0]     wkup_cfg_i,
  // One-cycle clear strobes
  input  logic      [`PINWKUP_NUM_DET-1:0]     cause_clr_i,
  // Sticky cause levels
  output logic      [`PINWKUP_NUM_DET-1:0]     cause_o,
  // Request to the power manager
  output logic                                 wkup_req_o
);

  ////////////////////////////////////////
  // Detector bank
  ////////////////////////////////////////

  for (genvar i = 0; i < `PINWKUP_NUM_DET; i++) begin : g_det
    // Per-detector slices
    logic      det_pad;
    wkup_cfg_t det_cfg;
    logic      det_clr;
    logic      det_cause;

    assign det_pad = pad_i[i];
    assign det_cfg = wkup_cfg_i[i];
    assign det_clr = cause_clr_i[i];

    pinwkup_detector i_det (
      .clk_aon_i   (clk_aon_i),
      .rst_aon_ni  (rst_aon_ni),
      .pad_i       (det_pad),
      .cfg_i       (det_cfg),
      .cause_clr_i (det_clr),
      .cause_o     (det_cause)
    );

    assign cause_o[i] = det_cause;
  end

  // Any pending cause keeps the request up
  assign wkup_req_o = |cause_o;

endmodule : pinwkup_top

`default_nettype wire

// File: hw/pinwkup_detector.sv
// Single pin wakeup detector
// Config latch, optional debounce, pad synchronizer, pattern match,
// sticky cause bit

`timescale 1ns/1ps
`default_nettype none

module pinwkup_detector import pinwkup_pkg::*; (
  input  logic      clk_aon_i,
  input  logic      rst_aon_ni,
  input  logic      pad_i,
  input  wkup_cfg_t cfg_i,
  input  logic      cause_clr_i,
  output logic      cause_o
);

  ////////////////////////////////////////
  // Config latch
  ////////////////////////////////////////

  // Registered enable plus the fields captured when it rose
  wkup_cfg_t cfg_q;
  logic      en_rise;

  assign en_rise = cfg_i.en & ~cfg_q.en;

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin : p_cfg
    if (!rst_aon_ni) begin
      cfg_q.en        <= 1'b0;
      cfg_q.filter_en <= 1'b0;
      cfg_q.mode      <= WKUP_POSEDGE;
      cfg_q.cnt_th    <= '0;
    end else begin
      cfg_q.en <= cfg_i.en;
      // Take mode, filter and threshold only on the enable edge
      // Later changes while enabled are ignored
      if (en_rise) begin
        cfg_q.filter_en <= cfg_i.filter_en;
        cfg_q.mode      <= cfg_i.mode;
        cfg_q.cnt_th    <= cfg_i.cnt_th;
      end
    end
  end

  ////////////////////////////////////////
  // Filter and synchronizer
  ////////////////////////////////////////

  logic       pad_filt;
  logic [1:0] sync_q;
  logic       pad_sync;
  logic       prev_q;

  pinwkup_filter i_filter (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .enable_i   (cfg_q.filter_en),
    .pad_i      (pad_i),
    .filt_o     (pad_filt)
  );

  // Two flops against metastability, then one for edge history
  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin : p_sync
    if (!rst_aon_ni) begin
      sync_q <= 2'b00;
      prev_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], pad_filt};
      prev_q <= sync_q[1];
    end
  end

  assign pad_sync = sync_q[1];

  ////////////////////////////////////////
  // Pattern matching
  ////////////////////////////////////////

  logic rising;
  logic falling;
  assign rising  =  pad_sync & ~prev_q;
  assign falling = ~pad_sync &  prev_q;

  // Timed modes count cycles at the wanted level
  wkup_cnt_t cnt_q;
  wkup_cnt_t cnt_d;
  logic      cnt_en;
  logic      cnt_hit;
  logic      match;

  assign cnt_hit = cnt_en & (cnt_q == cfg_q.cnt_th);

  // Restart on a hit or whenever the level is lost
  assign cnt_d = (cnt_en && !cnt_hit) ? cnt_q + 1'b1 : '0;

  always_comb begin : p_mode
    match  = 1'b0;
    cnt_en = 1'b0;
    // Nothing matches while disabled
    if (cfg_q.en) begin
      case (cfg_q.mode)
        WKUP_NEGEDGE: match = falling;
        WKUP_EDGE:    match = rising | falling;
        WKUP_HIGH_TIMED: begin
          cnt_en = pad_sync;
          match  = cnt_hit;
        end
        WKUP_LOW_TIMED: begin
          cnt_en = ~pad_sync;
          match  = cnt_hit;
        end
        // Rising edge, also for undefined codes
        default:      match = rising;
      endcase
    end
  end

  ////////////////////////////////////////
  // Counter and cause
  ////////////////////////////////////////

  logic cause_q;

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin : p_cause
    if (!rst_aon_ni) begin
      cnt_q   <= '0;
      cause_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      // Clear beats a match in the same cycle
      if (cause_clr_i) begin
        cause_q <= 1'b0;
      end else if (match) begin
        cause_q <= 1'b1;
      end
    end
  end

  // Sticky until software clears it
  assign cause_o = cause_q;

endmodule : pinwkup_detector

`default_nettype wire

// File: hw/pinwkup_filter.sv
// Pad debounce filter with combinational bypass
// Output follows the pad only after it has been stable long enough

`timescale 1ns/1ps
`default_nettype none

`include "pinwkup_config.svh"

module pinwkup_filter import pinwkup_pkg::*; (
  input  logic clk_aon_i,
  input  logic rst_aon_ni,
  input  logic enable_i,
  input  logic pad_i,
  output logic filt_o
);

  // Last pad value seen, and how long it has held
  logic      sample_q;
  filt_cnt_t stable_cnt_q;
  // Debounced value
  logic      filt_q;

  logic pad_changed;
  assign pad_changed = (pad_i != sample_q);

  ////////////////////////////////////////
  // Stability tracking
  ////////////////////////////////////////

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin : p_filter
    if (!rst_aon_ni) begin
      sample_q     <= 1'b0;
      stable_cnt_q <= '0;
      filt_q       <= 1'b0;
    end else begin
      if (pad_changed) begin
        // New value, restart the count
        sample_q     <= pad_i;
        stable_cnt_q <= '0;
      end else if (stable_cnt_q != FILT_STABLE) begin
        // Saturate once the full length is reached
        stable_cnt_q <= stable_cnt_q + 1'b1;
      end
      // Held long enough, let it through
      if (stable_cnt_q == FILT_STABLE) begin
        filt_q <= sample_q;
      end
    end
  end

  // Bypass gives the raw pad with no retiming
  assign filt_o = enable_i ? filt_q : pad_i;

endmodule : pinwkup_filter

`default_nettype wire

// File: hw/pinwkup_pkg.sv
// Types shared by the pin wakeup detector bank
// Wakeup mode encoding, counter types and per-detector config struct

`default_nettype none

`include "pinwkup_config.svh"

package pinwkup_pkg;

  // Pattern to match on the synchronized pad
  // Undefined codes fall back to rising edge
  typedef enum logic [2:0] {
    WKUP_POSEDGE    = 3'd0,
    WKUP_NEGEDGE    = 3'd1,
    WKUP_EDGE       = 3'd2,
    WKUP_HIGH_TIMED = 3'd3,
    WKUP_LOW_TIMED  = 3'd4
  } wkup_mode_e;

  // Timed-mode counter and threshold
  typedef logic [`PINWKUP_CNT_WIDTH-1:0] wkup_cnt_t;

  // Debounce stability counter, wide enough to hold the full length
  localparam int unsigned FILT_CNT_W = $clog2(`PINWKUP_FILTER_CYCLES) + 1;
  typedef logic [FILT_CNT_W-1:0] filt_cnt_t;
  localparam filt_cnt_t FILT_STABLE = filt_cnt_t'(`PINWKUP_FILTER_CYCLES);

  // Per-detector configuration, as software would program it
  typedef struct packed {
    logic       en;
    logic       filter_en;
    wkup_mode_e mode;
    wkup_cnt_t  cnt_th;
  } wkup_cfg_t;

endpackage : pinwkup_pkg

`default_nettype wire

// File: hw/pinwkup_config.svh
// Build-time sizing for the pin wakeup detector bank
// Detector count, timed-mode counter width, debounce length

`ifndef PINWKUP_CONFIG_SVH
`define PINWKUP_CONFIG_SVH

// Number of detectors, one pad each
`define PINWKUP_NUM_DET 4

// Width of timed-mode counter and its threshold
`define PINWKUP_CNT_WIDTH 8

// Consecutive equal samples needed before the filter output moves
`define PINWKUP_FILTER_CYCLES 4

`endif
